/* common/fm_macros.svh */
/* register map and sizing of the FM register front end
   timer B prescale must stay a power of two */
`ifndef FM_MACROS_SVH
`define FM_MACROS_SVH

// channels and sequencer slots, four operators per channel
`define FM_NUM_CH     6
`define FM_NUM_SLOT   24

// timers
`define FM_TA_W       10
`define FM_TB_W       8
`define FM_TB_DIV     16

// global register addresses, anything below this is global
`define FM_REG_GLOBAL_END 8'h30
`define FM_REG_TESTYM     8'h21
`define FM_REG_LFO        8'h22
`define FM_REG_CLKA1      8'h24
`define FM_REG_CLKA2      8'h25
`define FM_REG_CLKB       8'h26
`define FM_REG_TIMER      8'h27
`define FM_REG_KON        8'h28
`define FM_REG_PCM        8'h2A
`define FM_REG_PCM_EN     8'h2B
`define FM_REG_DACTEST    8'h2C
`define FM_REG_CLK_N6     8'h2D
`define FM_REG_CLK_N3     8'h2E
`define FM_REG_CLK_N2     8'h2F

`endif

/* common/fm_pkg.sv */
/* shared types of the FM register front end
   channel numbers in fm_upd_t and fm_slot_params_t run 0 to 5 */
package fm_pkg;

	// host port, odd addr carries data, addr[1] picks the upper bank
	typedef struct packed {
		logic [1:0] addr;
		logic [7:0] din;
		logic       write;
	} fm_bus_t;

	typedef enum logic [2:0] {
		KON,
		FNUM_LO,
		BLK_FNUM_HI,
		FB_ALG,
		DT1_MUL,
		TL,
		KS_AR
	} fm_upd_kind_e;

	typedef struct packed {
		logic         valid;
		fm_upd_kind_e kind;
		logic [2:0]   ch;
		logic [1:0]   op;
		logic [7:0]   data;
	} fm_upd_t;

	// fast mirrors glob.fast_timers for the timer block
	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       irq_en_a;
		logic       irq_en_b;
		logic       clr_a;
		logic       clr_b;
		logic       fast;
	} fm_timer_cfg_t;

	typedef struct packed {
		logic       lfo_en;
		logic [2:0] lfo_freq;
		logic [8:0] pcm;
		logic       pcm_en;
		logic       fast_timers;
		logic       eg_stop;
		logic       pg_stop;
	} fm_global_t;

	typedef struct packed {
		logic [2:0]  ch;
		logic [1:0]  op;
		logic        keyon;
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [2:0]  dt1;
		logic [3:0]  mul;
		logic [6:0]  tl;
		logic [1:0]  ks;
		logic [4:0]  ar;
	} fm_slot_params_t;

endpackage

/* hdl/fm_timers.sv */
`timescale 1ns/100ps
/* timers A and B, counters sit at their start value while load is low
   flags set only with the irq enable, clr wins over a same-cycle overflow */
`include "fm_macros.svh"

module fm_timers (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	input  logic                  sample,
	input  fm_pkg::fm_timer_cfg_t tcfg,
	output logic                  flag_a,
	output logic                  flag_b,
	output logic                  irq
);
	localparam int PRE_W = $clog2(`FM_TB_DIV);

	logic [`FM_TA_W-1:0] cnt_a;
	logic [`FM_TB_W-1:0] cnt_b;
	logic [PRE_W-1:0]    pre_b;
	logic                tick_a;
	logic                tick_b;
	logic                ovf_a;
	logic                ovf_b;

	// fast mode steps both timers on every clk_en
	assign tick_a = tcfg.fast ? clk_en : sample;
	assign tick_b = tcfg.fast ? clk_en : (sample && pre_b == PRE_W'(`FM_TB_DIV - 1));

	assign ovf_a = tick_a && tcfg.load_a && (&cnt_a);
	assign ovf_b = tick_b && tcfg.load_b && (&cnt_b);

	always_ff @(posedge clk) begin
		if (rst)
			cnt_a <= '0;
		else if (!tcfg.load_a || ovf_a)
			cnt_a <= tcfg.value_a;
		else if (tick_a)
			cnt_a <= cnt_a + 1'b1;
	end

	// timer B prescaler restarts with each load
	always_ff @(posedge clk) begin
		if (rst || !tcfg.load_b)
			pre_b <= '0;
		else if (sample)
			pre_b <= pre_b + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			cnt_b <= '0;
		else if (!tcfg.load_b || ovf_b)
			cnt_b <= tcfg.value_b;
		else if (tick_b)
			cnt_b <= cnt_b + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (tcfg.clr_a)
				flag_a <= 1'b0;
			else if (ovf_a && tcfg.irq_en_a)
				flag_a <= 1'b1;
			if (tcfg.clr_b)
				flag_b <= 1'b0;
			else if (ovf_b && tcfg.irq_en_b)
				flag_b <= 1'b1;
		end
	end

	assign irq = flag_a | flag_b;

	flag_a_gated: assert property (@(posedge clk) disable iff (rst)
		$rose(flag_a) |-> $past(tcfg.irq_en_a));
	flag_b_gated: assert property (@(posedge clk) disable iff (rst)
		$rose(flag_b) |-> $past(tcfg.irq_en_b));

endmodule

/* mmr/fm_mmr.sv */
`timescale 1ns/100ps
/* host write decode, one write per rising edge of bus.write, applied one clk after sampling
   busy covers the whole write; the host should wait for it low between writes */
`include "fm_macros.svh"

module fm_mmr (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cen,
	input  fm_pkg::fm_bus_t       bus,
	input  logic                  slot_busy,
	output logic                  clk_en,
	output logic                  busy,
	output fm_pkg::fm_upd_t       upd,
	output fm_pkg::fm_global_t    glob,
	output fm_pkg::fm_timer_cfg_t tcfg
);
	import fm_pkg::*;

	logic [2:0]   cen_cnt;
	logic [2:0]   cen_lim;
	fm_bus_t      bus_q;
	logic         old_write;
	logic         wr_edge;
	logic [7:0]   sel_reg;
	logic [2:0]   up_ch;
	logic [1:0]   up_op;
	fm_upd_kind_e kind;
	logic         kind_ok;

	// bank bit plus sub-channel to a 0..5 channel index
	function automatic logic [2:0] ch_index(input logic bank, input logic [1:0] sub);
		return bank ? 3'(sub) + 3'd3 : 3'(sub);
	endfunction

	// clock enable divider, limit 5/2/1 gives /6, /3, /2
	assign clk_en = cen && (cen_cnt >= cen_lim);

	always_ff @(posedge clk) begin
		if (rst)
			cen_cnt <= 3'd0;
		else if (cen)
			cen_cnt <= clk_en ? 3'd0 : cen_cnt + 3'd1;
	end

	assign wr_edge = bus_q.write && !old_write;

	// which stored register the selected address targets
	always_comb begin
		kind = FNUM_LO;
		kind_ok = 1'b1;
		case (sel_reg[7:2])
			6'h28: kind = FNUM_LO;
			6'h29: kind = BLK_FNUM_HI;
			6'h2C: kind = FB_ALG;
			default: begin
				case (sel_reg[7:4])
					4'h3: kind = DT1_MUL;
					4'h4: kind = TL;
					4'h5: kind = KS_AR;
					default: kind_ok = 1'b0;
				endcase
			end
		endcase
		// slot 3 of each group does not exist
		if (sel_reg[1:0] == 2'b11)
			kind_ok = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bus_q     <= '0;
			old_write <= 1'b0;
			sel_reg   <= 8'h00;
			up_ch     <= 3'd0;
			up_op     <= 2'd0;
			cen_lim   <= 3'd5;
			busy      <= 1'b0;
			upd       <= '0;
			glob      <= '0;
			tcfg      <= '0;
		end else begin
			bus_q <= bus;
			old_write <= bus_q.write;
			upd.valid <= 1'b0;
			if (wr_edge) begin
				busy <= 1'b1;
				if (!bus_q.addr[0]) begin
					sel_reg <= bus_q.din;
					up_ch <= {bus_q.addr[1], bus_q.din[1:0]};
					// op order 0=S1 1=S3 2=S2 3=S4
					up_op <= bus_q.din[3:2];
				end else if (sel_reg < `FM_REG_GLOBAL_END) begin
					case (sel_reg)
						`FM_REG_TESTYM: begin
							glob.eg_stop <= bus_q.din[5];
							glob.pg_stop <= bus_q.din[3];
							glob.fast_timers <= bus_q.din[2];
							tcfg.fast <= bus_q.din[2];
						end
						`FM_REG_LFO: {glob.lfo_en, glob.lfo_freq} <= bus_q.din[3:0];
						`FM_REG_CLKA1: tcfg.value_a[9:2] <= bus_q.din;
						`FM_REG_CLKA2: tcfg.value_a[1:0] <= bus_q.din[1:0];
						`FM_REG_CLKB: tcfg.value_b <= bus_q.din;
						`FM_REG_TIMER: begin
							{tcfg.clr_b, tcfg.clr_a, tcfg.irq_en_b, tcfg.irq_en_a,
								tcfg.load_b, tcfg.load_a} <= bus_q.din[5:0];
						end
						`FM_REG_KON: begin
							// channel in din[2:0], operator keys in din[7:4]
							if (bus_q.din[1:0] != 2'b11) begin
								upd.valid <= 1'b1;
								upd.kind <= KON;
								upd.ch <= ch_index(bus_q.din[2], bus_q.din[1:0]);
								upd.op <= 2'd0;
								upd.data <= bus_q.din;
							end
						end
						`FM_REG_PCM: glob.pcm[8:1] <= bus_q.din;
						`FM_REG_DACTEST: glob.pcm[0] <= bus_q.din[3];
						`FM_REG_PCM_EN: glob.pcm_en <= bus_q.din[7];
						`FM_REG_CLK_N6: cen_lim <= 3'd5;
						`FM_REG_CLK_N3: cen_lim <= 3'd2;
						`FM_REG_CLK_N2: cen_lim <= 3'd1;
						default: ;
					endcase
				end else if (kind_ok) begin
					upd.valid <= 1'b1;
					upd.kind <= kind;
					upd.ch <= ch_index(up_ch[2], up_ch[1:0]);
					upd.op <= up_op;
					upd.data <= bus_q.din;
				end
			end else if (clk_en) begin
				// flag clears are one-shot
				tcfg.clr_a <= 1'b0;
				tcfg.clr_b <= 1'b0;
				// upd still in flight is not yet seen in slot_busy
				if (!slot_busy && !upd.valid)
					busy <= 1'b0;
			end
		end
	end

	upd_one_shot: assert property (@(posedge clk) disable iff (rst) upd.valid |=> !upd.valid);

endmodule

/* mmr/fm_slot_regs.sv */
`timescale 1ns/100ps
/* per-slot parameter store, one pending write per register kind at a time
   a newer write of the same kind replaces one not yet applied */
`include "fm_macros.svh"

module fm_slot_regs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    clk_en,
	input  fm_pkg::fm_upd_t         upd,
	output logic                    slot_busy,
	output logic                    sample,
	output fm_pkg::fm_slot_params_t slot_params
);
	import fm_pkg::*;

	localparam int NS = `FM_NUM_SLOT;
	localparam int NC = `FM_NUM_CH;
	localparam int K_LO = int'(FNUM_LO);
	localparam int K_HI = int'(KS_AR);

	logic [4:0]    slot;
	logic [2:0]    cur_ch;
	logic [1:0]    cur_op;
	logic          chan_kind;
	logic [4:0]    upd_slot;
	logic [NS-1:0] upd_bit;

	// channel storage
	logic [10:0] fnum_mem [NC];
	logic [2:0]  block_mem [NC];
	logic [2:0]  fb_mem [NC];
	logic [2:0]  alg_mem [NC];
	// operator storage, indexed by slot
	logic [2:0] dt1_mem [NS];
	logic [3:0] mul_mem [NS];
	logic [6:0] tl_mem [NS];
	logic [1:0] ks_mem [NS];
	logic [4:0] ar_mem [NS];
	logic       keyon_mem [NS];

	logic [NS-1:0] pend [K_LO:K_HI];
	logic [7:0]    lat [K_LO:K_HI];
	logic          kon_pend;
	logic [2:0]    kon_ch;
	logic [3:0]    kon_bits;

	// channel-major, four operators per channel
	assign cur_ch = slot[4:2];
	assign cur_op = slot[1:0];

	// channel registers land on the channel's first slot
	assign chan_kind = upd.kind inside {FNUM_LO, BLK_FNUM_HI, FB_ALG};
	assign upd_slot = {upd.ch, chan_kind ? 2'b00 : upd.op};
	assign upd_bit = NS'(1) << upd_slot;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= 5'd0;
			sample <= 1'b0;
			kon_pend <= 1'b0;
			for (int k = K_LO; k <= K_HI; k++)
				pend[k] <= '0;
			for (int c = 0; c < NC; c++) begin
				fnum_mem[c] <= '0;
				block_mem[c] <= '0;
				fb_mem[c] <= '0;
				alg_mem[c] <= '0;
			end
			for (int s = 0; s < NS; s++) begin
				dt1_mem[s] <= '0;
				mul_mem[s] <= '0;
				tl_mem[s] <= '0;
				ks_mem[s] <= '0;
				ar_mem[s] <= '0;
				keyon_mem[s] <= 1'b0;
			end
		end else begin
			sample <= 1'b0;
			if (clk_en) begin
				slot <= (slot == 5'(NS - 1)) ? 5'd0 : slot + 5'd1;
				sample <= slot == 5'(NS - 1);
				// key bits din[7:4] are S1 S2 S3 S4
				if (kon_pend) begin
					keyon_mem[{kon_ch, 2'd0}] <= kon_bits[0];
					keyon_mem[{kon_ch, 2'd1}] <= kon_bits[2];
					keyon_mem[{kon_ch, 2'd2}] <= kon_bits[1];
					keyon_mem[{kon_ch, 2'd3}] <= kon_bits[3];
					kon_pend <= 1'b0;
				end
				if (pend[FNUM_LO][slot])
					fnum_mem[cur_ch][7:0] <= lat[FNUM_LO];
				if (pend[BLK_FNUM_HI][slot])
					{block_mem[cur_ch], fnum_mem[cur_ch][10:8]} <= lat[BLK_FNUM_HI][5:0];
				if (pend[FB_ALG][slot])
					{fb_mem[cur_ch], alg_mem[cur_ch]} <= lat[FB_ALG][5:0];
				if (pend[DT1_MUL][slot])
					{dt1_mem[slot], mul_mem[slot]} <= lat[DT1_MUL][6:0];
				if (pend[TL][slot])
					tl_mem[slot] <= lat[TL][6:0];
				if (pend[KS_AR][slot]) begin
					ks_mem[slot] <= lat[KS_AR][7:6];
					ar_mem[slot] <= lat[KS_AR][4:0];
				end
				for (int k = K_LO; k <= K_HI; k++)
					pend[k][slot] <= 1'b0;
			end
			// a new request wins over the clear above
			if (upd.valid) begin
				if (upd.kind == KON) begin
					kon_pend <= 1'b1;
					kon_ch <= upd.ch;
					kon_bits <= upd.data[7:4];
				end else begin
					pend[upd.kind] <= upd_bit;
					lat[upd.kind] <= upd.data;
				end
			end
		end
	end

	always_comb begin
		slot_busy = kon_pend;
		for (int k = K_LO; k <= K_HI; k++)
			slot_busy = slot_busy | (|pend[k]);
	end

	always_comb begin
		slot_params.ch = cur_ch;
		slot_params.op = cur_op;
		slot_params.keyon = keyon_mem[slot];
		slot_params.fnum = fnum_mem[cur_ch];
		slot_params.block = block_mem[cur_ch];
		slot_params.fb = fb_mem[cur_ch];
		slot_params.alg = alg_mem[cur_ch];
		slot_params.dt1 = dt1_mem[slot];
		slot_params.mul = mul_mem[slot];
		slot_params.tl = tl_mem[slot];
		slot_params.ks = ks_mem[slot];
		slot_params.ar = ar_mem[slot];
	end

	slot_range: assert property (@(posedge clk) disable iff (rst) slot < 5'(NS));

endmodule

/* hdl/fm_regs_top.sv */
`timescale 1ns/100ps
/* FM register front end, host port in, per-slot parameters out
   cen is the chip clock enable, divided internally to clk_en */
module fm_regs_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cen,
	input  fm_pkg::fm_bus_t         bus,
	output logic                    busy,
	output logic                    irq,
	output logic                    flag_a,
	output logic                    flag_b,
	output logic                    sample,
	output logic                    clk_en,
	output fm_pkg::fm_global_t      glob,
	output fm_pkg::fm_slot_params_t slot_params
);
	import fm_pkg::*;

	logic          slot_busy;
	fm_upd_t       upd;
	fm_timer_cfg_t tcfg;

	fm_mmr u_mmr (
		.clk       (clk),
		.rst       (rst),
		.cen       (cen),
		.bus       (bus),
		.slot_busy (slot_busy),
		.clk_en    (clk_en),
		.busy      (busy),
		.upd       (upd),
		.glob      (glob),
		.tcfg      (tcfg)
	);

	fm_slot_regs u_slot_regs (
		.clk         (clk),
		.rst         (rst),
		.clk_en      (clk_en),
		.upd         (upd),
		.slot_busy   (slot_busy),
		.sample      (sample),
		.slot_params (slot_params)
	);

	fm_timers u_timers (
		.clk    (clk),
		.rst    (rst),
		.clk_en (clk_en),
		.sample (sample),
		.tcfg   (tcfg),
		.flag_a (flag_a),
		.flag_b (flag_b),
		.irq    (irq)
	);

endmodule

/* verification/fm_checker.sv */
`timescale 1ns/100ps
/* compares DUT outputs with the testbench model on every rising clk
   expects channel-major slot order, four slots per channel */
`include "fm_macros.svh"

module fm_checker (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    clk_en,
	input  logic                    sample,
	input  logic                    irq,
	input  logic                    flag_a,
	input  logic                    flag_b,
	input  fm_pkg::fm_global_t      glob,
	input  fm_pkg::fm_slot_params_t slot_params,
	input  fm_pkg::fm_global_t      exp_glob,
	input  fm_pkg::fm_slot_params_t exp_slots [`FM_NUM_SLOT],
	input  logic                    slot_check_en,
	input  logic                    div_check_en,
	input  int                      exp_div,
	input  logic [1:0]              exp_flags,
	output int                      checks,
	output int                      errors
);
	import fm_pkg::*;

	int   exp_slot;
	int   gap;
	logic armed;
	logic sample_due;

	initial begin
		checks = 0;
		errors = 0;
	end

	task automatic expect_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// values seen here are the ones settled before the edge
	always @(posedge clk) begin
		if (rst) begin
			exp_slot = 0;
			gap = 0;
			armed = 1'b0;
			sample_due = 1'b0;
		end else begin
			expect_value("sample", 64'(sample), 64'(sample_due));
			expect_value("glob", 64'(glob), 64'(exp_glob));
			expect_value("flag_a", 64'(flag_a), 64'(exp_flags[0]));
			expect_value("flag_b", 64'(flag_b), 64'(exp_flags[1]));
			expect_value("irq", 64'(irq), 64'(|exp_flags));
			if (slot_check_en)
				expect_value($sformatf("slot_params of slot %0d", exp_slot),
					64'(slot_params), 64'(exp_slots[exp_slot]));
			// clocks between two clk_en pulses
			if (!div_check_en)
				armed = 1'b0;
			if (clk_en) begin
				if (armed)
					expect_value("clk_en period", 64'(gap), 64'(exp_div));
				armed = div_check_en;
				gap = 1;
			end else begin
				gap++;
			end
			sample_due = clk_en && (exp_slot == `FM_NUM_SLOT - 1);
			if (clk_en)
				exp_slot = (exp_slot == `FM_NUM_SLOT - 1) ? 0 : exp_slot + 1;
		end
	end

endmodule

/* verification/fm_tb.sv */
`timescale 1ns/100ps
/* random register writes against a model of the FM front end, cen held high
   the host waits for busy low after each write */
`include "fm_macros.svh"

module fm_tb;
	import fm_pkg::*;

	localparam longint CLK_NS = 8;
	localparam longint SAMPLE_NS = 64'(`FM_NUM_SLOT) * 6 * CLK_NS;
	// timer A needs up to 1024 samples, timer B up to 4096, with margin for the rest
	localparam longint WATCHDOG_NS = 4 * (1024 + 256 * `FM_TB_DIV) * SAMPLE_NS;

	logic            clk = 1'b0;
	logic            rst;
	logic            cen;
	fm_bus_t         bus;
	logic            busy;
	logic            irq;
	logic            flag_a;
	logic            flag_b;
	logic            sample;
	logic            clk_en;
	fm_global_t      glob;
	fm_slot_params_t slot_params;
	fm_global_t      exp_glob;
	fm_slot_params_t exp_slots [`FM_NUM_SLOT];
	logic            slot_check_en;
	logic            div_check_en;
	int              exp_div;
	logic [1:0]      exp_flags;
	int              checks;
	int              chk_errors;
	int              tb_errors;
	logic [31:0]     lfsr_state = 32'h62d7;

	always #(CLK_NS / 2) clk = ~clk;

	fm_regs_top UUT (
		.clk         (clk),
		.rst         (rst),
		.cen         (cen),
		.bus         (bus),
		.busy        (busy),
		.irq         (irq),
		.flag_a      (flag_a),
		.flag_b      (flag_b),
		.sample      (sample),
		.clk_en      (clk_en),
		.glob        (glob),
		.slot_params (slot_params)
	);

	fm_checker chk (
		.clk           (clk),
		.rst           (rst),
		.clk_en        (clk_en),
		.sample        (sample),
		.irq           (irq),
		.flag_a        (flag_a),
		.flag_b        (flag_b),
		.glob          (glob),
		.slot_params   (slot_params),
		.exp_glob      (exp_glob),
		.exp_slots     (exp_slots),
		.slot_check_en (slot_check_en),
		.div_check_en  (div_check_en),
		.exp_div       (exp_div),
		.exp_flags     (exp_flags),
		.checks        (checks),
		.errors        (chk_errors)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// write pulse on one falling edge, dropped on the next; applied before return
	task automatic host_write(input logic [1:0] addr, input logic [7:0] din);
		@(negedge clk);
		bus.addr = addr;
		bus.din = din;
		bus.write = 1'b1;
		@(negedge clk);
		bus.write = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (busy && n < 1000) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			tb_errors++;
			$display("busy still high 1000 clocks after a write, at %0t ns", $time);
		end
	endtask

	// register map of the chip applied to the model
	task automatic model_write(input logic bank, input logic [7:0] r, input logic [7:0] d);
		int ch;
		int s;
		int o;
		ch = int'(bank) * 3 + int'(r[1:0]);
		s = ch * 4 + int'(r[3:2]);
		case (r)
			`FM_REG_TESTYM: begin
				exp_glob.eg_stop = d[5];
				exp_glob.pg_stop = d[3];
				exp_glob.fast_timers = d[2];
			end
			`FM_REG_LFO: {exp_glob.lfo_en, exp_glob.lfo_freq} = d[3:0];
			`FM_REG_PCM: exp_glob.pcm[8:1] = d;
			`FM_REG_DACTEST: exp_glob.pcm[0] = d[3];
			`FM_REG_PCM_EN: exp_glob.pcm_en = d[7];
			`FM_REG_CLK_N6: exp_div = 6;
			`FM_REG_CLK_N3: exp_div = 3;
			`FM_REG_CLK_N2: exp_div = 2;
			`FM_REG_KON: begin
				// key bits 4..7 are S1 S2 S3 S4, slots run S1 S3 S2 S4
				if (d[1:0] != 2'b11) begin
					ch = int'(d[2]) * 3 + int'(d[1:0]);
					exp_slots[ch * 4].keyon = d[4];
					exp_slots[ch * 4 + 1].keyon = d[6];
					exp_slots[ch * 4 + 2].keyon = d[5];
					exp_slots[ch * 4 + 3].keyon = d[7];
				end
			end
			default: begin
				if (r >= 8'h30 && r[1:0] != 2'b11) begin
					for (o = ch * 4; o < ch * 4 + 4; o++) begin
						case (r[7:2])
							6'h28: exp_slots[o].fnum[7:0] = d;
							6'h29: {exp_slots[o].block, exp_slots[o].fnum[10:8]} = d[5:0];
							6'h2C: {exp_slots[o].fb, exp_slots[o].alg} = d[5:0];
							default: ;
						endcase
					end
					case (r[7:4])
						4'h3: {exp_slots[s].dt1, exp_slots[s].mul} = d[6:0];
						4'h4: exp_slots[s].tl = d[6:0];
						4'h5: begin
							exp_slots[s].ks = d[7:6];
							exp_slots[s].ar = d[4:0];
						end
						default: ;
					endcase
				end
			end
		endcase
	endtask

	// slot compare paused while the DUT catches up with the model
	task automatic reg_write(input logic bank, input logic [7:0] r, input logic [7:0] d);
		slot_check_en = 1'b0;
		host_write({bank, 1'b0}, r);
		host_write({bank, 1'b1}, d);
		// busy rose on the edge that took the data write
		chk.expect_value("busy", 64'(busy), 64'(1));
		model_write(bank, r, d);
		wait_not_busy();
		slot_check_en = 1'b1;
	endtask

	task automatic global_test();
		logic [7:0] r;
		repeat (30) begin
			case (take_bits(3) % 5)
				0: r = `FM_REG_TESTYM;
				1: r = `FM_REG_LFO;
				2: r = `FM_REG_PCM;
				3: r = `FM_REG_PCM_EN;
				default: r = `FM_REG_DACTEST;
			endcase
			reg_write(1'b0, r, 8'(take_bits(8)));
		end
	endtask

	task automatic divider_test(input logic [7:0] r);
		reg_write(1'b0, r, 8'h00);
		div_check_en = 1'b1;
		repeat (12 * exp_div) @(negedge clk);
		div_check_en = 1'b0;
	endtask

	task automatic slot_write_test();
		logic [7:0] r;
		repeat (80) begin
			case (take_bits(3) % 6)
				0: r = 8'h30 | 8'(take_bits(4));
				1: r = 8'h40 | 8'(take_bits(4));
				2: r = 8'h50 | 8'(take_bits(4));
				3: r = 8'hA0 | 8'(take_bits(2));
				4: r = 8'hA4 | 8'(take_bits(2));
				default: r = 8'hB0 | 8'(take_bits(2));
			endcase
			reg_write(take_bits(1) == 1, r, 8'(take_bits(8)));
		end
		repeat (16) reg_write(1'b0, `FM_REG_KON, 8'(take_bits(8)));
	endtask

	// samples from load to flag, counted while sample is high
	task automatic timer_test(input logic is_b);
		logic [9:0] val;
		int n;
		int exp_n;
		val = 10'(take_bits(is_b ? 8 : 10));
		exp_n = is_b ? (256 - int'(val)) * `FM_TB_DIV : 1024 - int'(val);
		n = 0;
		reg_write(1'b0, `FM_REG_TIMER, 8'h30);
		if (is_b) begin
			reg_write(1'b0, `FM_REG_CLKB, val[7:0]);
		end else begin
			reg_write(1'b0, `FM_REG_CLKA1, val[9:2]);
			reg_write(1'b0, `FM_REG_CLKA2, {6'd0, val[1:0]});
		end
		host_write(2'b00, `FM_REG_TIMER);
		host_write(2'b01, is_b ? 8'h0A : 8'h05);
		// the flag rises on the edge after the last counted sample
		while (n < exp_n) begin
			if (sample)
				n++;
			@(negedge clk);
		end
		exp_flags = is_b ? 2'b10 : 2'b01;
		reg_write(1'b0, `FM_REG_TIMER, is_b ? 8'h20 : 8'h10);
		exp_flags = 2'b00;
	endtask

	initial begin
		rst = 1'b1;
		cen = 1'b1;
		bus = '0;
		slot_check_en = 1'b0;
		div_check_en = 1'b0;
		exp_div = 6;
		exp_flags = 2'b00;
		tb_errors = 0;
		exp_glob = '0;
		for (int s = 0; s < `FM_NUM_SLOT; s++) begin
			exp_slots[s] = '0;
			exp_slots[s].ch = 3'(s / 4);
			exp_slots[s].op = 2'(s % 4);
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		slot_check_en = 1'b1;

		global_test();
		divider_test(`FM_REG_CLK_N3);
		divider_test(`FM_REG_CLK_N2);
		divider_test(`FM_REG_CLK_N6);
		slot_write_test();
		// fast timer mode off, faster divider for the long timer runs
		reg_write(1'b0, `FM_REG_TESTYM, 8'h00);
		divider_test(`FM_REG_CLK_N2);
		timer_test(1'b0);
		timer_test(1'b1);
		repeat (2 * `FM_NUM_SLOT * 6) @(negedge clk);

		$display("%0d checks, %0d checker errors, %0d testbench errors",
			checks, chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/fm_pkg.sv
hdl/fm_timers.sv
mmr/fm_mmr.sv
mmr/fm_slot_regs.sv
hdl/fm_regs_top.sv
verification/fm_checker.sv
verification/fm_tb.sv

/* Makefile */
# Verilator build and run of the FM register front end testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fm_tb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
